// ==== rtl/bpc_pkg.sv ====
package bpc_pkg;

	// quantized coefficient, bit 16 carries the sign
	typedef logic [16:0] coef_t;

	// bit-plane count, 0 to 12
	typedef logic [3:0] plane_t;

	// decomposition level, 0 to 4
	typedef logic [2:0] level_t;

	// colour component: y=0, u=1, v=2
	typedef logic [1:0] comp_t;

	// subband index
	typedef logic [1:0] band_t;

	localparam band_t BAND_LL = 2'd0;
	localparam band_t BAND_LH = 2'd1;
	localparam band_t BAND_HL = 2'd2;
	localparam band_t BAND_HH = 2'd3;

	// table geometry
	localparam int NUM_LEVELS = 5;
	localparam int NUM_COMPS = 3;

	// LL lives only at the coarsest level
	localparam level_t TOP_LEVEL = 3'd4;

	// magnitude bits that take part in the search
	// MAG_LSB maps to plane 1, MAG_MSB to plane 12
	localparam int MAG_MSB = 15;
	localparam int MAG_LSB = 4;

	// burst tracking in the controller
	typedef enum logic {
		IDLE,
		BURST
	} ctrl_state_e;

endpackage

// ==== rtl/burst_ctrl.sv ====
`timescale 1ns/100ps
module burst_ctrl (
	input  logic             clk_mmu,
	input  logic             rst,
	input  logic             clr,
	input  logic             quant_out_vld,
	input  bpc_pkg::level_t  level,
	input  bpc_pkg::comp_t   comp,
	output logic             max_clr,
	output logic             wr_en,
	output bpc_pkg::level_t  wr_level,
	output bpc_pkg::comp_t   wr_comp
);

	bpc_pkg::ctrl_state_e state;
	bpc_pkg::ctrl_state_e state_nxt;
	logic                 burst_start;
	// valid delayed to match the coefficient and plane stages
	logic                 vld_d1;
	logic                 vld_d2;

	assign burst_start = (state == bpc_pkg::IDLE) && quant_out_vld;

	always_comb begin
		state_nxt = state;
		case (state)
			bpc_pkg::IDLE: begin
				if (quant_out_vld) begin
					state_nxt = bpc_pkg::BURST;
				end
			end
			bpc_pkg::BURST: begin
				if (!quant_out_vld) begin
					state_nxt = bpc_pkg::IDLE;
				end
			end
			default: state_nxt = bpc_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_mmu or negedge rst) begin
		if (!rst) begin
			state    <= bpc_pkg::IDLE;
			vld_d1   <= 1'b0;
			vld_d2   <= 1'b0;
			max_clr  <= 1'b0;
			wr_en    <= 1'b0;
			wr_level <= '0;
			wr_comp  <= '0;
		end else if (clr) begin
			state    <= bpc_pkg::IDLE;
			vld_d1   <= 1'b0;
			vld_d2   <= 1'b0;
			max_clr  <= 1'b0;
			wr_en    <= 1'b0;
			wr_level <= '0;
			wr_comp  <= '0;
		end else begin
			state  <= state_nxt;
			vld_d1 <= quant_out_vld;
			vld_d2 <= vld_d1;
			// first plane count of the burst is in the count register next cycle
			max_clr <= vld_d1 && !vld_d2;
			// falling edge of the count stage, running max is final next cycle
			wr_en <= vld_d2 && !vld_d1;
			if (burst_start) begin
				wr_level <= level;
				wr_comp  <= comp;
			end
		end
	end

	// comp 3 has no table column
	a_comp_legal: assert property (@(posedge clk_mmu) disable iff (!rst)
		quant_out_vld |-> comp != 2'd3);

endmodule

// ==== rtl/band_plane_max.sv ====
`timescale 1ns/100ps
module band_plane_max (
	input  logic             clk_mmu,
	input  logic             rst,
	input  logic             clr,
	input  logic             quant_out_vld,
	input  logic             max_clr,
	input  bpc_pkg::coef_t   coef,
	output bpc_pkg::plane_t  band_max
);

	bpc_pkg::coef_t  coef_q;
	bpc_pkg::plane_t plane_nxt;
	bpc_pkg::plane_t plane_q;

	// leading one over the magnitude window, higher bits overwrite lower
	always_comb begin
		plane_nxt = '0;
		for (int i = bpc_pkg::MAG_LSB; i <= bpc_pkg::MAG_MSB; i++) begin
			if (coef_q[i]) begin
				plane_nxt = bpc_pkg::plane_t'(i - bpc_pkg::MAG_LSB + 1);
			end
		end
	end

	always_ff @(posedge clk_mmu or negedge rst) begin
		if (!rst) begin
			coef_q   <= '0;
			plane_q  <= '0;
			band_max <= '0;
		end else if (clr) begin
			coef_q   <= '0;
			plane_q  <= '0;
			band_max <= '0;
		end else begin
			// coefficient holds between beats so the count stays stable
			if (quant_out_vld) begin
				coef_q <= coef;
			end
			plane_q <= plane_nxt;
			if (max_clr) begin
				band_max <= plane_q;
			end else if (plane_q > band_max) begin
				band_max <= plane_q;
			end
		end
	end

	// the search window tops out at plane 12
	a_max_range: assert property (@(posedge clk_mmu) disable iff (!rst)
		band_max <= bpc_pkg::plane_t'(bpc_pkg::MAG_MSB - bpc_pkg::MAG_LSB + 1));

endmodule

// ==== rtl/plane_count_table.sv ====
`timescale 1ns/100ps
module plane_count_table (
	input  logic             clk_mmu,
	input  logic             rst,
	input  logic             clr,
	input  logic             wr_en,
	input  bpc_pkg::level_t  wr_level,
	input  bpc_pkg::comp_t   wr_comp,
	input  bpc_pkg::plane_t  max_ll,
	input  bpc_pkg::plane_t  max_lh,
	input  bpc_pkg::plane_t  max_hl,
	input  bpc_pkg::plane_t  max_hh,
	input  bpc_pkg::level_t  rd_level,
	input  bpc_pkg::band_t   rd_band,
	input  bpc_pkg::comp_t   rd_comp,
	output bpc_pkg::plane_t  rd_count
);

	// detail subbands per component and level
	bpc_pkg::plane_t lh_mem [bpc_pkg::NUM_COMPS][bpc_pkg::NUM_LEVELS];
	bpc_pkg::plane_t hl_mem [bpc_pkg::NUM_COMPS][bpc_pkg::NUM_LEVELS];
	bpc_pkg::plane_t hh_mem [bpc_pkg::NUM_COMPS][bpc_pkg::NUM_LEVELS];
	// LL at the top level only
	bpc_pkg::plane_t ll_mem [bpc_pkg::NUM_COMPS];

	logic wr_ok;
	logic rd_ok;

	assign wr_ok = wr_en && (wr_level <= bpc_pkg::TOP_LEVEL) &&
		(wr_comp < bpc_pkg::comp_t'(bpc_pkg::NUM_COMPS));
	assign rd_ok = (rd_level <= bpc_pkg::TOP_LEVEL) &&
		(rd_comp < bpc_pkg::comp_t'(bpc_pkg::NUM_COMPS));

	always_ff @(posedge clk_mmu or negedge rst) begin
		if (!rst) begin
			for (int c = 0; c < bpc_pkg::NUM_COMPS; c++) begin
				ll_mem[c] <= '0;
				for (int l = 0; l < bpc_pkg::NUM_LEVELS; l++) begin
					lh_mem[c][l] <= '0;
					hl_mem[c][l] <= '0;
					hh_mem[c][l] <= '0;
				end
			end
		end else if (clr) begin
			for (int c = 0; c < bpc_pkg::NUM_COMPS; c++) begin
				ll_mem[c] <= '0;
				for (int l = 0; l < bpc_pkg::NUM_LEVELS; l++) begin
					lh_mem[c][l] <= '0;
					hl_mem[c][l] <= '0;
					hh_mem[c][l] <= '0;
				end
			end
		end else if (wr_ok) begin
			lh_mem[wr_comp][wr_level] <= max_lh;
			hl_mem[wr_comp][wr_level] <= max_hl;
			hh_mem[wr_comp][wr_level] <= max_hh;
			if (wr_level == bpc_pkg::TOP_LEVEL) begin
				ll_mem[wr_comp] <= max_ll;
			end
		end
	end

	// unmapped addresses read as zero
	always_comb begin
		rd_count = '0;
		if (rd_ok) begin
			case (rd_band)
				bpc_pkg::BAND_LL: begin
					if (rd_level == bpc_pkg::TOP_LEVEL) begin
						rd_count = ll_mem[rd_comp];
					end
				end
				bpc_pkg::BAND_LH: rd_count = lh_mem[rd_comp][rd_level];
				bpc_pkg::BAND_HL: rd_count = hl_mem[rd_comp][rd_level];
				bpc_pkg::BAND_HH: rd_count = hh_mem[rd_comp][rd_level];
				default: rd_count = '0;
			endcase
		end
	end

	// a clear must not race a pending write
	a_no_wr_on_clr: assert property (@(posedge clk_mmu) disable iff (!rst)
		clr |-> !wr_en);

endmodule

// ==== rtl/bit_plane_count.sv ====
`timescale 1ns/100ps
module bit_plane_count (
	input  logic             clk_mmu,
	input  logic             rst,
	input  logic             clr,
	input  logic             quant_out_vld,
	input  bpc_pkg::coef_t   dina_ll,
	input  bpc_pkg::coef_t   dina_lh,
	input  bpc_pkg::coef_t   dina_hl,
	input  bpc_pkg::coef_t   dina_hh,
	input  bpc_pkg::level_t  level,
	input  bpc_pkg::comp_t   comp,
	input  bpc_pkg::level_t  rd_level,
	input  bpc_pkg::band_t   rd_band,
	input  bpc_pkg::comp_t   rd_comp,
	output bpc_pkg::plane_t  rd_count
);

	logic            max_clr;
	logic            wr_en;
	bpc_pkg::level_t wr_level;
	bpc_pkg::comp_t  wr_comp;
	bpc_pkg::plane_t max_ll;
	bpc_pkg::plane_t max_lh;
	bpc_pkg::plane_t max_hl;
	bpc_pkg::plane_t max_hh;

	burst_ctrl u_ctrl (
		.clk_mmu       (clk_mmu),
		.rst           (rst),
		.clr           (clr),
		.quant_out_vld (quant_out_vld),
		.level         (level),
		.comp          (comp),
		.max_clr       (max_clr),
		.wr_en         (wr_en),
		.wr_level      (wr_level),
		.wr_comp       (wr_comp)
	);

	// one pipeline per subband
	band_plane_max u_ll (
		.clk_mmu       (clk_mmu),
		.rst           (rst),
		.clr           (clr),
		.quant_out_vld (quant_out_vld),
		.max_clr       (max_clr),
		.coef          (dina_ll),
		.band_max      (max_ll)
	);

	band_plane_max u_lh (
		.clk_mmu       (clk_mmu),
		.rst           (rst),
		.clr           (clr),
		.quant_out_vld (quant_out_vld),
		.max_clr       (max_clr),
		.coef          (dina_lh),
		.band_max      (max_lh)
	);

	band_plane_max u_hl (
		.clk_mmu       (clk_mmu),
		.rst           (rst),
		.clr           (clr),
		.quant_out_vld (quant_out_vld),
		.max_clr       (max_clr),
		.coef          (dina_hl),
		.band_max      (max_hl)
	);

	band_plane_max u_hh (
		.clk_mmu       (clk_mmu),
		.rst           (rst),
		.clr           (clr),
		.quant_out_vld (quant_out_vld),
		.max_clr       (max_clr),
		.coef          (dina_hh),
		.band_max      (max_hh)
	);

	plane_count_table u_table (
		.clk_mmu  (clk_mmu),
		.rst      (rst),
		.clr      (clr),
		.wr_en    (wr_en),
		.wr_level (wr_level),
		.wr_comp  (wr_comp),
		.max_ll   (max_ll),
		.max_lh   (max_lh),
		.max_hl   (max_hl),
		.max_hh   (max_hh),
		.rd_level (rd_level),
		.rd_band  (rd_band),
		.rd_comp  (rd_comp),
		.rd_count (rd_count)
	);

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/100ps
module tb_clk_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	// free-running, starts low
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

// ==== dv/tb_bit_plane_count.sv ====
`timescale 1ns/100ps
module tb_bit_plane_count;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_RANDOM = 40;
	localparam int MAX_LEN = 16;
	// random bursts, big/small pair, zero case, twelve single-bit cases
	localparam int NUM_BURSTS = NUM_RANDOM + 2 + 1 + 12;
	localparam int NUM_SCANS = 3;
	localparam int SCAN_READS = 128;
	localparam int WATCHDOG_NS =
		(NUM_BURSTS * (MAX_LEN + 10) + NUM_SCANS * SCAN_READS) * CLK_PERIOD * 2;

	logic            clk_mmu;
	logic            rst;
	logic            clr;
	logic            quant_out_vld;
	bpc_pkg::coef_t  dina_ll;
	bpc_pkg::coef_t  dina_lh;
	bpc_pkg::coef_t  dina_hl;
	bpc_pkg::coef_t  dina_hh;
	bpc_pkg::level_t level;
	bpc_pkg::comp_t  comp;
	bpc_pkg::level_t rd_level;
	bpc_pkg::band_t  rd_band;
	bpc_pkg::comp_t  rd_comp;
	bpc_pkg::plane_t rd_count;

	logic [31:0]     seed;
	int              errors;
	int              checks;
	// expected counts by comp, level, band; unmapped entries stay 0
	bpc_pkg::plane_t model_tab [4][8][4];
	bpc_pkg::coef_t  burst_coef [4][MAX_LEN];

	tb_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.clk(clk_mmu));

	bit_plane_count u_bit_plane_count (
		.clk_mmu       (clk_mmu),
		.rst           (rst),
		.clr           (clr),
		.quant_out_vld (quant_out_vld),
		.dina_ll       (dina_ll),
		.dina_lh       (dina_lh),
		.dina_hl       (dina_hl),
		.dina_hh       (dina_hh),
		.level         (level),
		.comp          (comp),
		.rd_level      (rd_level),
		.rd_band       (rd_band),
		.rd_comp       (rd_comp),
		.rd_count      (rd_count)
	);

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// plane is the number of significant bits in magnitude bits 15..4
	function automatic bpc_pkg::plane_t plane_of(input bpc_pkg::coef_t c);
		logic [11:0]     mag;
		bpc_pkg::plane_t p;
		mag = c[15:4];
		p = '0;
		while (mag != 12'd0) begin
			p = p + 4'd1;
			mag = mag >> 1;
		end
		return p;
	endfunction

	function automatic bpc_pkg::coef_t rand_coef();
		logic [31:0] r;
		r = next_rand();
		// random shift spreads the leading one over all planes
		return {r[31], r[30:15] >> r[11:8]};
	endfunction

	task automatic check_read(input bpc_pkg::level_t l, input bpc_pkg::band_t b,
		input bpc_pkg::comp_t c, input bpc_pkg::plane_t exp);
		@(negedge clk_mmu);
		rd_level = l;
		rd_band = b;
		rd_comp = c;
		#10;
		checks++;
		if (rd_count !== exp) begin
			errors++;
			$display("FAIL %0t rd_count (level %0d band %0d comp %0d): got %0d, expected %0d",
				$time, l, b, c, rd_count, exp);
		end
	endtask

	task automatic scan_all();
		for (int c = 0; c < 4; c++) begin
			for (int l = 0; l < 8; l++) begin
				for (int b = 0; b < 4; b++) begin
					check_read(bpc_pkg::level_t'(l), bpc_pkg::band_t'(b),
						bpc_pkg::comp_t'(c), model_tab[c][l][b]);
				end
			end
		end
	endtask

	// plays burst_coef[*][0..len-1], updates the model, reads back the address
	task automatic run_burst(input bpc_pkg::level_t lvl, input bpc_pkg::comp_t cmp,
		input int len);
		bpc_pkg::plane_t mx [4];
		logic [31:0]     r;
		mx = '{default: '0};
		for (int i = 0; i < len; i++) begin
			r = next_rand();
			@(negedge clk_mmu);
			quant_out_vld = 1'b1;
			// level and comp only count on the first beat
			level = (i == 0) ? lvl : r[2:0];
			comp = (i == 0) ? cmp : bpc_pkg::comp_t'(r[5:3] % 3'd3);
			dina_ll = burst_coef[0][i];
			dina_lh = burst_coef[1][i];
			dina_hl = burst_coef[2][i];
			dina_hh = burst_coef[3][i];
			for (int b = 0; b < 4; b++) begin
				if (plane_of(burst_coef[b][i]) > mx[b]) begin
					mx[b] = plane_of(burst_coef[b][i]);
				end
			end
		end
		@(negedge clk_mmu);
		quant_out_vld = 1'b0;
		repeat (8) @(negedge clk_mmu);
		for (int b = 1; b < 4; b++) begin
			model_tab[cmp][lvl][b] = mx[b];
		end
		if (lvl == bpc_pkg::TOP_LEVEL) begin
			model_tab[cmp][lvl][0] = mx[0];
		end
		for (int b = 0; b < 4; b++) begin
			check_read(lvl, bpc_pkg::band_t'(b), cmp, model_tab[cmp][lvl][b]);
		end
	endtask

	initial begin
		logic [31:0] r;
		int          len;
		rst = 1'b0;
		clr = 1'b0;
		quant_out_vld = 1'b0;
		dina_ll = '0;
		dina_lh = '0;
		dina_hl = '0;
		dina_hh = '0;
		level = '0;
		comp = '0;
		rd_level = '0;
		rd_band = '0;
		rd_comp = '0;
		seed = 32'hbaaa;
		errors = 0;
		checks = 0;
		model_tab = '{default: '0};
		burst_coef = '{default: '0};
		repeat (3) @(posedge clk_mmu);
		@(negedge clk_mmu);
		rst = 1'b1;
		scan_all();
		// random bursts at random addresses
		for (int n = 0; n < NUM_RANDOM; n++) begin
			r = next_rand();
			len = 1 + int'(r[19:16]);
			for (int i = 0; i < len; i++) begin
				for (int b = 0; b < 4; b++) begin
					burst_coef[b][i] = rand_coef();
				end
			end
			run_burst(bpc_pkg::level_t'(r[22:20] % 3'd5), bpc_pkg::comp_t'(r[26:24] % 3'd3), len);
		end
		// large maxima, then small ones at the same address
		for (int i = 0; i < 4; i++) begin
			for (int b = 0; b < 4; b++) begin
				burst_coef[b][i] = 17'h18000;
			end
		end
		run_burst(3'd2, 2'd1, 4);
		for (int i = 0; i < 4; i++) begin
			for (int b = 0; b < 4; b++) begin
				burst_coef[b][i] = bpc_pkg::coef_t'(17'h0001f >> i);
			end
		end
		run_burst(3'd2, 2'd1, 4);
		scan_all();
		// sign bit and low bits alone
		burst_coef[0][0] = 17'h10000;
		burst_coef[1][0] = 17'h0000f;
		burst_coef[2][0] = 17'h1000f;
		burst_coef[3][0] = 17'h00000;
		run_burst(bpc_pkg::TOP_LEVEL, 2'd0, 1);
		// one leading bit at each searched position
		for (int p = 4; p <= 15; p++) begin
			burst_coef[0][0] = bpc_pkg::coef_t'(17'd1 << p);
			burst_coef[1][0] = bpc_pkg::coef_t'(17'h10000 | (17'd1 << p));
			burst_coef[2][0] = bpc_pkg::coef_t'((17'd1 << p) | 17'h0000f);
			burst_coef[3][0] = bpc_pkg::coef_t'((17'd1 << p) | ((17'd1 << p) - 17'd1));
			run_burst(bpc_pkg::TOP_LEVEL, 2'd0, 1);
			check_read(bpc_pkg::TOP_LEVEL, bpc_pkg::BAND_HH, 2'd0, bpc_pkg::plane_t'(p - 3));
		end
		@(negedge clk_mmu);
		clr = 1'b1;
		@(negedge clk_mmu);
		clr = 1'b0;
		model_tab = '{default: '0};
		scan_all();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: test sequence did not complete within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== list.f ====
rtl/bpc_pkg.sv
rtl/burst_ctrl.sv
rtl/band_plane_max.sv
rtl/plane_count_table.sv
rtl/bit_plane_count.sv
dv/tb_clk_gen.sv
dv/tb_bit_plane_count.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator from list.f, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f list.f --top-module tb_bit_plane_count -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -qF "** PASS **" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
